/* hdl/issue_pkg.sv */
package issue_pkg;

    // Major opcodes.
    localparam logic [5:0] SPECIAL = 6'b000000;
    localparam logic [5:0] REGIMM  = 6'b000001;
    localparam logic [5:0] J       = 6'b000010;
    localparam logic [5:0] JAL     = 6'b000011;
    localparam logic [5:0] BEQ     = 6'b000100;
    localparam logic [5:0] BNE     = 6'b000101;
    localparam logic [5:0] BLEZ    = 6'b000110;
    localparam logic [5:0] BGTZ    = 6'b000111;
    localparam logic [5:0] ADDIU   = 6'b001001;
    localparam logic [5:0] SLTI    = 6'b001010;
    localparam logic [5:0] ANDI    = 6'b001100;
    localparam logic [5:0] ORI     = 6'b001101;
    localparam logic [5:0] XORI    = 6'b001110;
    localparam logic [5:0] LUI     = 6'b001111;
    localparam logic [5:0] COP0    = 6'b010000;
    localparam logic [5:0] LB      = 6'b100000;
    localparam logic [5:0] LH      = 6'b100001;
    localparam logic [5:0] LW      = 6'b100011;
    localparam logic [5:0] LBU     = 6'b100100;
    localparam logic [5:0] LHU     = 6'b100101;
    localparam logic [5:0] SB      = 6'b101000;
    localparam logic [5:0] SH      = 6'b101001;
    localparam logic [5:0] SW      = 6'b101011;

    // SPECIAL funct codes.
    localparam logic [5:0] SLL     = 6'b000000;
    localparam logic [5:0] SRL     = 6'b000010;
    localparam logic [5:0] SRA     = 6'b000011;
    localparam logic [5:0] JR      = 6'b001000;
    localparam logic [5:0] JALR    = 6'b001001;
    localparam logic [5:0] SYSCALL = 6'b001100;
    localparam logic [5:0] BREAK   = 6'b001101;
    localparam logic [5:0] MFHI    = 6'b010000;
    localparam logic [5:0] MTHI    = 6'b010001;
    localparam logic [5:0] MFLO    = 6'b010010;
    localparam logic [5:0] MTLO    = 6'b010011;
    localparam logic [5:0] MULT    = 6'b011000;
    localparam logic [5:0] MULTU   = 6'b011001;
    localparam logic [5:0] DIV     = 6'b011010;
    localparam logic [5:0] DIVU    = 6'b011011;
    localparam logic [5:0] ADDU    = 6'b100001;
    localparam logic [5:0] SUBU    = 6'b100011;
    localparam logic [5:0] AND     = 6'b100100;
    localparam logic [5:0] OR      = 6'b100101;
    localparam logic [5:0] XOR     = 6'b100110;
    localparam logic [5:0] NOR     = 6'b100111;
    localparam logic [5:0] SLT     = 6'b101010;
    localparam logic [5:0] SLTU    = 6'b101011;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

    typedef struct packed {
        logic [31:0] addr;
        instr_word_u instr;
    } fetch_entry_t;

    typedef struct packed {
        logic       memreq;
        logic       regwrite;
        logic       hiwrite;
        logic       lowrite;
        logic       is_branch;
        logic       is_jump;
        logic       need_rs;
        logic       need_rt;
        logic       need_hi;
        logic       need_lo;
        logic       cp0_rel;
        logic [4:0] dest;
    } instr_class_t;

    typedef struct packed {
        logic         valid;
        fetch_entry_t entry;
        logic         addr_err;
        logic         in_delay_slot;
    } issue_slot_t;

    typedef struct packed {
        issue_slot_t alpha;
        issue_slot_t beta;
    } issue_bundle_t;

endpackage

/* hdl/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  issue_pkg::fetch_entry_t  in_data,
    input  logic                     pop_one,
    input  logic                     pop_two,
    output logic                     in_ready,
    output issue_pkg::fetch_entry_t  head0,
    output issue_pkg::fetch_entry_t  head1,
    output logic [$clog2(QUEUE_DEPTH):0] count
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    issue_pkg::fetch_entry_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_inc;
    logic             push;
    logic [1:0]       pop_n;

    assign in_ready   = count != CNT_W'(QUEUE_DEPTH);
    assign push       = in_valid && in_ready;
    assign pop_n      = pop_two ? 2'd2 : (pop_one ? 2'd1 : 2'd0);

    // Pointers wrap naturally since the depth is a power of two.
    assign rd_ptr_inc = rd_ptr + PTR_W'(1);
    assign head0      = mem[rd_ptr];
    assign head1      = mem[rd_ptr_inc];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            rd_ptr <= rd_ptr + PTR_W'(pop_n);
            count  <= count + CNT_W'(push) - CNT_W'(pop_n);
        end
    end

    // Pops come from the issue decision downstream of this queue.
    a_pop_two_needs_two: assert property (@(posedge clk) disable iff (rst)
        pop_two |-> count >= CNT_W'(2));

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        (pop_one || pop_two) |-> count != '0);

endmodule

/* hdl/instr_classify.sv */
`timescale 1ns/1ps

module instr_classify (
    input  issue_pkg::instr_word_u  instr,
    output issue_pkg::instr_class_t cls
);

    logic [4:0] rs_rt_sel;
    logic [4:0] rd;
    logic [4:0] rt;
    logic [5:0] funct;

    assign rs_rt_sel = instr.i_fmt.rt;
    assign rt        = instr.i_fmt.rt;
    assign rd        = instr.r_fmt.rd;
    assign funct     = instr.r_fmt.funct;

    always_comb
    begin
        cls = '0;
        case (instr.r_fmt.op)
            issue_pkg::SPECIAL:
            begin
                case (funct)
                    issue_pkg::SLL, issue_pkg::SRL, issue_pkg::SRA:
                    begin
                        cls.regwrite = 1'b1;
                        cls.need_rt  = 1'b1;
                        cls.dest     = rd;
                    end
                    issue_pkg::JR:
                    begin
                        cls.is_jump = 1'b1;
                        cls.need_rs = 1'b1;
                    end
                    issue_pkg::JALR:
                    begin
                        cls.is_jump  = 1'b1;
                        cls.need_rs  = 1'b1;
                        cls.regwrite = 1'b1;
                        cls.dest     = 5'd31;
                    end
                    issue_pkg::SYSCALL, issue_pkg::BREAK:
                        cls.cp0_rel = 1'b1;
                    issue_pkg::MFHI:
                    begin
                        cls.regwrite = 1'b1;
                        cls.need_hi  = 1'b1;
                        cls.dest     = rd;
                    end
                    issue_pkg::MFLO:
                    begin
                        cls.regwrite = 1'b1;
                        cls.need_lo  = 1'b1;
                        cls.dest     = rd;
                    end
                    issue_pkg::MTHI:
                    begin
                        cls.hiwrite = 1'b1;
                        cls.need_rs = 1'b1;
                    end
                    issue_pkg::MTLO:
                    begin
                        cls.lowrite = 1'b1;
                        cls.need_rs = 1'b1;
                    end
                    issue_pkg::MULT, issue_pkg::MULTU, issue_pkg::DIV, issue_pkg::DIVU:
                    begin
                        cls.hiwrite = 1'b1;
                        cls.lowrite = 1'b1;
                        cls.need_rs = 1'b1;
                        cls.need_rt = 1'b1;
                    end
                    issue_pkg::ADDU, issue_pkg::SUBU, issue_pkg::AND, issue_pkg::OR,
                    issue_pkg::XOR, issue_pkg::NOR, issue_pkg::SLT, issue_pkg::SLTU:
                    begin
                        cls.regwrite = 1'b1;
                        cls.need_rs  = 1'b1;
                        cls.need_rt  = 1'b1;
                        cls.dest     = rd;
                    end
                    default:
                        cls = '0;
                endcase
            end
            issue_pkg::REGIMM:
            begin
                // BLTZ, BGEZ, BLTZAL and BGEZAL only.
                if (rs_rt_sel[3:1] == 3'b000)
                begin
                    cls.is_branch = 1'b1;
                    cls.need_rs   = 1'b1;
                    if (rs_rt_sel[4])
                    begin
                        cls.regwrite = 1'b1;
                        cls.dest     = 5'd31;
                    end
                end
            end
            issue_pkg::J:
                cls.is_jump = 1'b1;
            issue_pkg::JAL:
            begin
                cls.is_jump  = 1'b1;
                cls.regwrite = 1'b1;
                cls.dest     = 5'd31;
            end
            issue_pkg::BEQ, issue_pkg::BNE:
            begin
                cls.is_branch = 1'b1;
                cls.need_rs   = 1'b1;
                cls.need_rt   = 1'b1;
            end
            issue_pkg::BLEZ, issue_pkg::BGTZ:
            begin
                cls.is_branch = 1'b1;
                cls.need_rs   = 1'b1;
            end
            issue_pkg::ADDIU, issue_pkg::SLTI, issue_pkg::ANDI, issue_pkg::ORI,
            issue_pkg::XORI:
            begin
                cls.regwrite = 1'b1;
                cls.need_rs  = 1'b1;
                cls.dest     = rt;
            end
            issue_pkg::LUI:
            begin
                cls.regwrite = 1'b1;
                cls.dest     = rt;
            end
            issue_pkg::COP0:
                cls.cp0_rel = 1'b1;
            issue_pkg::LB, issue_pkg::LH, issue_pkg::LW, issue_pkg::LBU, issue_pkg::LHU:
            begin
                cls.memreq   = 1'b1;
                cls.regwrite = 1'b1;
                cls.need_rs  = 1'b1;
                cls.dest     = rt;
            end
            issue_pkg::SB, issue_pkg::SH, issue_pkg::SW:
            begin
                cls.memreq  = 1'b1;
                cls.need_rs = 1'b1;
                cls.need_rt = 1'b1;
            end
            default:
                cls = '0;
        endcase
    end

endmodule

/* hdl/pair_check.sv */
`timescale 1ns/1ps

module pair_check #(
    parameter int QUEUE_DEPTH = 4
) (
    input  issue_pkg::fetch_entry_t  head0,
    input  issue_pkg::fetch_entry_t  head1,
    input  issue_pkg::instr_class_t  cls_alpha,
    input  issue_pkg::instr_class_t  cls_beta,
    input  logic [$clog2(QUEUE_DEPTH):0] count,
    input  logic                     slot_pending,
    output issue_pkg::issue_bundle_t bundle,
    output logic                     issue_second
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

    logic alpha_jb;
    logic reg_hazard;
    logic hilo_hazard;
    logic beta_blocked;

    assign alpha_jb = cls_alpha.is_branch || cls_alpha.is_jump;

    // Writes to r0 never create a dependence.
    assign reg_hazard = cls_alpha.regwrite && (cls_alpha.dest != 5'd0) &&
        ((cls_beta.need_rs && (cls_alpha.dest == head1.instr.r_fmt.rs)) ||
         (cls_beta.need_rt && (cls_alpha.dest == head1.instr.r_fmt.rt)));

    assign hilo_hazard = (cls_alpha.hiwrite && cls_beta.need_hi) ||
                         (cls_alpha.lowrite && cls_beta.need_lo);

    assign beta_blocked = cls_beta.is_branch || cls_beta.is_jump ||
                          cls_beta.memreq ||
                          slot_pending ||
                          cls_alpha.cp0_rel || cls_beta.cp0_rel ||
                          reg_hazard || hilo_hazard;

    assign issue_second = (count >= CNT_W'(2)) && !beta_blocked;

    always_comb
    begin
        bundle.alpha.valid         = count != '0;
        bundle.alpha.entry         = head0;
        bundle.alpha.addr_err      = head0.addr[1:0] != 2'b00;
        bundle.alpha.in_delay_slot = slot_pending;

        bundle.beta.valid          = issue_second;
        bundle.beta.entry          = head1;
        bundle.beta.addr_err       = head1.addr[1:0] != 2'b00;
        bundle.beta.in_delay_slot  = alpha_jb;
    end

endmodule

/* hdl/delay_slot_fsm.sv */
`timescale 1ns/1ps

module delay_slot_fsm (
    input  logic clk,
    input  logic rst,
    input  logic out_fire,
    input  logic alpha_jb,
    input  logic beta_issued,
    output logic slot_pending
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_SLOT = 1'b1;

    logic state;
    logic state_next;

    always_comb
    begin
        state_next = state;
        if (out_fire)
        begin
            // A lone branch leaves its delay slot for the next bundle.
            if (alpha_jb && !beta_issued)
            begin
                state_next = ST_SLOT;
            end
            else
            begin
                state_next = ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    assign slot_pending = state == ST_SLOT;

    // No branch may sit in a delay slot.
    a_no_branch_in_slot: assert property (@(posedge clk) disable iff (rst)
        (out_fire && slot_pending) |-> !alpha_jb);

endmodule

/* hdl/issue_stats.sv */
`timescale 1ns/1ps

module issue_stats (
    input  logic        clk,
    input  logic        rst,
    input  logic        out_fire,
    input  logic        beta_issued,
    output logic [31:0] issued_count,
    output logic [31:0] dual_count
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            issued_count <= '0;
            dual_count   <= '0;
        end
        else if (out_fire)
        begin
            issued_count <= issued_count + (beta_issued ? 32'd2 : 32'd1);
            if (beta_issued)
            begin
                dual_count <= dual_count + 32'd1;
            end
        end
    end

endmodule

/* hdl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  issue_pkg::fetch_entry_t  in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output issue_pkg::issue_bundle_t out_bundle,
    output logic [31:0]              issued_count,
    output logic [31:0]              dual_count
);

    issue_pkg::fetch_entry_t head0;
    issue_pkg::fetch_entry_t head1;
    issue_pkg::instr_class_t cls_alpha;
    issue_pkg::instr_class_t cls_beta;

    logic [$clog2(QUEUE_DEPTH):0] count;
    logic issue_second;
    logic slot_pending;
    logic out_fire;

    assign out_valid = count != '0;
    assign out_fire  = out_valid && out_ready;

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .pop_one  (out_fire && !issue_second),
        .pop_two  (out_fire && issue_second),
        .in_ready (in_ready),
        .head0    (head0),
        .head1    (head1),
        .count    (count)
    );

    instr_classify u_cls_alpha (
        .instr (head0.instr),
        .cls   (cls_alpha)
    );

    instr_classify u_cls_beta (
        .instr (head1.instr),
        .cls   (cls_beta)
    );

    pair_check #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_pair_check (
        .head0        (head0),
        .head1        (head1),
        .cls_alpha    (cls_alpha),
        .cls_beta     (cls_beta),
        .count        (count),
        .slot_pending (slot_pending),
        .bundle       (out_bundle),
        .issue_second (issue_second)
    );

    delay_slot_fsm u_delay_slot_fsm (
        .clk          (clk),
        .rst          (rst),
        .out_fire     (out_fire),
        .alpha_jb     (cls_alpha.is_branch || cls_alpha.is_jump),
        .beta_issued  (issue_second),
        .slot_pending (slot_pending)
    );

    issue_stats u_issue_stats (
        .clk          (clk),
        .rst          (rst),
        .out_fire     (out_fire),
        .beta_issued  (issue_second),
        .issued_count (issued_count),
        .dual_count   (dual_count)
    );

endmodule

/* tb/issue_ref.svh */
`ifndef ISSUE_REF_SVH
`define ISSUE_REF_SVH

// Expected attributes of one instruction word.
function automatic issue_pkg::instr_class_t ref_classify(issue_pkg::instr_word_u w);
    issue_pkg::instr_class_t c;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rt;
    logic sp;
    logic alu_r;
    logic shift;
    logic muldiv;
    logic mtx;
    logic mfx;
    logic alu_i;
    logic load;
    logic store;
    logic cond_br;
    logic regimm_br;
    logic link;
    logic rd_write;
    logic rt_write;
    op = w.r_fmt.op;
    fn = w.r_fmt.funct;
    rt = w.i_fmt.rt;
    sp = op == issue_pkg::SPECIAL;
    alu_r = sp && (fn inside {issue_pkg::ADDU, issue_pkg::SUBU, issue_pkg::AND, issue_pkg::OR,
        issue_pkg::XOR, issue_pkg::NOR, issue_pkg::SLT, issue_pkg::SLTU});
    shift = sp && (fn inside {issue_pkg::SLL, issue_pkg::SRL, issue_pkg::SRA});
    muldiv = sp && (fn inside {issue_pkg::MULT, issue_pkg::MULTU, issue_pkg::DIV,
        issue_pkg::DIVU});
    mtx = sp && (fn inside {issue_pkg::MTHI, issue_pkg::MTLO});
    mfx = sp && (fn inside {issue_pkg::MFHI, issue_pkg::MFLO});
    alu_i = op inside {issue_pkg::ADDIU, issue_pkg::SLTI, issue_pkg::ANDI, issue_pkg::ORI,
        issue_pkg::XORI};
    load = op inside {issue_pkg::LB, issue_pkg::LH, issue_pkg::LW, issue_pkg::LBU,
        issue_pkg::LHU};
    store = op inside {issue_pkg::SB, issue_pkg::SH, issue_pkg::SW};
    cond_br = op inside {issue_pkg::BEQ, issue_pkg::BNE, issue_pkg::BLEZ, issue_pkg::BGTZ};
    // BLTZ, BGEZ and their linking forms.
    regimm_br = (op == issue_pkg::REGIMM) && (rt inside {5'd0, 5'd1, 5'd16, 5'd17});
    link = (op == issue_pkg::JAL) || (sp && fn == issue_pkg::JALR) || (regimm_br && rt[4]);
    rd_write = alu_r || shift || mfx;
    rt_write = alu_i || load || (op == issue_pkg::LUI);

    c = '0;
    c.memreq = load || store;
    c.is_branch = cond_br || regimm_br;
    c.is_jump = (op inside {issue_pkg::J, issue_pkg::JAL}) ||
        (sp && (fn inside {issue_pkg::JR, issue_pkg::JALR}));
    c.hiwrite = muldiv || (sp && fn == issue_pkg::MTHI);
    c.lowrite = muldiv || (sp && fn == issue_pkg::MTLO);
    c.need_hi = sp && fn == issue_pkg::MFHI;
    c.need_lo = sp && fn == issue_pkg::MFLO;
    c.cp0_rel = (op == issue_pkg::COP0) ||
        (sp && (fn inside {issue_pkg::SYSCALL, issue_pkg::BREAK}));
    c.need_rs = alu_r || muldiv || mtx || alu_i || load || store || cond_br || regimm_br ||
        (sp && (fn inside {issue_pkg::JR, issue_pkg::JALR}));
    c.need_rt = alu_r || shift || muldiv || store ||
        (op inside {issue_pkg::BEQ, issue_pkg::BNE});
    c.regwrite = rd_write || rt_write || link;
    if (link)
        c.dest = 5'd31;
    else if (rd_write)
        c.dest = w.r_fmt.rd;
    else if (rt_write)
        c.dest = rt;
    return c;
endfunction

// Expected bundle for the n oldest entries, n counted up to two.
function automatic issue_pkg::issue_bundle_t ref_bundle(issue_pkg::fetch_entry_t e0,
    issue_pkg::fetch_entry_t e1, int n, logic slot);
    issue_pkg::instr_class_t a;
    issue_pkg::instr_class_t b;
    issue_pkg::issue_bundle_t bnd;
    logic dep;
    logic solo;
    a = ref_classify(e0.instr);
    b = ref_classify(e1.instr);
    dep = 1'b0;
    if (a.regwrite && a.dest != 5'd0)
    begin
        dep = (b.need_rs && e1.instr.i_fmt.rs == a.dest) ||
            (b.need_rt && e1.instr.i_fmt.rt == a.dest);
    end
    if ((a.hiwrite && b.need_hi) || (a.lowrite && b.need_lo))
        dep = 1'b1;
    solo = b.is_branch || b.is_jump || b.memreq || slot || a.cp0_rel || b.cp0_rel;

    bnd = '0;
    bnd.alpha.valid = n >= 1;
    bnd.alpha.entry = e0;
    bnd.alpha.addr_err = e0.addr[1:0] != 2'b00;
    bnd.alpha.in_delay_slot = slot;
    bnd.beta.valid = (n >= 2) && !dep && !solo;
    bnd.beta.entry = e1;
    bnd.beta.addr_err = e1.addr[1:0] != 2'b00;
    bnd.beta.in_delay_slot = a.is_branch || a.is_jump;
    return bnd;
endfunction

`endif

/* tb/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;

    localparam int QUEUE_DEPTH = 4;
    localparam int RESET_CYCLES = 5;
    localparam int N_RANDOM = 80;

    localparam logic [5:0] ALU_FUNCTS [8] = '{issue_pkg::ADDU, issue_pkg::SUBU,
        issue_pkg::AND, issue_pkg::OR, issue_pkg::XOR, issue_pkg::NOR, issue_pkg::SLT,
        issue_pkg::SLTU};
    localparam logic [5:0] IMM_OPS [5] = '{issue_pkg::ADDIU, issue_pkg::SLTI,
        issue_pkg::ANDI, issue_pkg::ORI, issue_pkg::XORI};
    localparam logic [5:0] LOAD_OPS [5] = '{issue_pkg::LB, issue_pkg::LH, issue_pkg::LW,
        issue_pkg::LBU, issue_pkg::LHU};
    localparam logic [5:0] STORE_OPS [3] = '{issue_pkg::SB, issue_pkg::SH, issue_pkg::SW};
    localparam logic [5:0] MULDIV_FUNCTS [4] = '{issue_pkg::MULT, issue_pkg::MULTU,
        issue_pkg::DIV, issue_pkg::DIVU};
    localparam logic [4:0] REGIMM_RT [4] = '{5'd0, 5'd1, 5'd16, 5'd17};

    logic clk = 1'b0;
    logic rst;
    logic in_valid;
    logic in_ready;
    issue_pkg::fetch_entry_t in_data;
    logic out_valid;
    logic out_ready;
    issue_pkg::issue_bundle_t out_bundle;
    logic [31:0] issued_count;
    logic [31:0] dual_count;

    issue_pkg::fetch_entry_t stim[$];
    issue_pkg::fetch_entry_t model_q[$];
    logic model_slot = 1'b0;
    logic saw_full = 1'b0;
    int accepted = 0;
    int exp_dual = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;
    logic [31:0] pc;

    `include "issue_ref.svh"

    issue_stage #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_issue_stage (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_bundle   (out_bundle),
        .issued_count (issued_count),
        .dual_count   (dual_count)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first failure.");
    endtask

    task automatic check_bundle(issue_pkg::issue_bundle_t got, issue_pkg::issue_bundle_t want);
        logic bad;
        bad = (got.alpha != want.alpha) || (got.beta.valid != want.beta.valid);
        // Beta fields only matter when beta issues.
        if (want.beta.valid && got.beta != want.beta)
            bad = 1'b1;
        if (bad)
        begin
            $display("Error at %0t: bundle alpha %h beta %h, expected alpha %h beta %h",
                $time, got.alpha, got.beta, want.alpha, want.beta);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(string what, logic got, logic want);
        if (got !== want)
        begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_counts(logic [31:0] got_issued, logic [31:0] got_dual,
        logic [31:0] want_issued, logic [31:0] want_dual);
        if (got_issued !== want_issued || got_dual !== want_dual)
        begin
            $display("Error at %0t: issued %0d dual %0d, expected issued %0d dual %0d",
                $time, got_issued, got_dual, want_issued, want_dual);
            stop_with_failure();
        end
    endtask

    function automatic int pick(int n);
        return int'($urandom % n);
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'($urandom % 8);
    endfunction

    function automatic issue_pkg::instr_word_u r_word(logic [5:0] funct, logic [4:0] rs,
        logic [4:0] rt, logic [4:0] rd);
        return {issue_pkg::SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic issue_pkg::instr_word_u i_word(logic [5:0] op, logic [4:0] rs,
        logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_entry(issue_pkg::instr_word_u w, logic [1:0] skew);
        issue_pkg::fetch_entry_t e;
        e.addr = pc | 32'(skew);
        e.instr = w;
        stim.push_back(e);
        pc = pc + 32'd4;
    endtask

    task automatic build_directed();
        // Independent ALU pairs.
        add_entry(r_word(issue_pkg::ADDU, 5'd1, 5'd2, 5'd3), 2'd0);
        add_entry(i_word(issue_pkg::ORI, 5'd4, 5'd5, 16'h00ff), 2'd0);
        add_entry(r_word(issue_pkg::ADDU, 5'd1, 5'd2, 5'd6), 2'd0);
        add_entry(r_word(issue_pkg::SUBU, 5'd6, 5'd7, 5'd8), 2'd0);
        // Writes to r0 create no dependence.
        add_entry(r_word(issue_pkg::OR, 5'd1, 5'd2, 5'd0), 2'd0);
        add_entry(r_word(issue_pkg::AND, 5'd0, 5'd3, 5'd4), 2'd0);
        add_entry(r_word(issue_pkg::MULT, 5'd1, 5'd2, 5'd0), 2'd0);
        add_entry(r_word(issue_pkg::MFHI, 5'd0, 5'd0, 5'd5), 2'd0);
        add_entry(r_word(issue_pkg::MTLO, 5'd3, 5'd0, 5'd0), 2'd0);
        add_entry(r_word(issue_pkg::MFLO, 5'd0, 5'd0, 5'd6), 2'd0);
        add_entry(i_word(issue_pkg::ADDIU, 5'd1, 5'd2, 16'd4), 2'd0);
        add_entry(i_word(issue_pkg::LW, 5'd3, 5'd4, 16'd0), 2'd0);
        add_entry(r_word(issue_pkg::XOR, 5'd1, 5'd2, 5'd3), 2'd0);
        add_entry(i_word(issue_pkg::SW, 5'd5, 5'd6, 16'd8), 2'd0);
        add_entry(i_word(issue_pkg::COP0, 5'd0, 5'd0, 16'd0), 2'd0);
        add_entry(r_word(issue_pkg::ADDU, 5'd1, 5'd2, 5'd3), 2'd0);
        add_entry(r_word(issue_pkg::SYSCALL, 5'd0, 5'd0, 5'd0), 2'd0);
        add_entry(r_word(issue_pkg::BREAK, 5'd0, 5'd0, 5'd0), 2'd0);
        // Branches with their delay slots.
        add_entry(i_word(issue_pkg::BEQ, 5'd1, 5'd2, 16'd16), 2'd0);
        add_entry(r_word(issue_pkg::ADDU, 5'd3, 5'd4, 5'd5), 2'd0);
        add_entry(i_word(issue_pkg::BNE, 5'd1, 5'd2, 16'd8), 2'd0);
        add_entry(i_word(issue_pkg::LW, 5'd3, 5'd4, 16'd0), 2'd0);
        add_entry(r_word(issue_pkg::ADDU, 5'd1, 5'd2, 5'd3), 2'd0);
        add_entry(i_word(issue_pkg::REGIMM, 5'd1, 5'd17, 16'd4), 2'd0);
        add_entry(r_word(issue_pkg::ADDU, 5'd31, 5'd2, 5'd5), 2'd0);
        add_entry(r_word(issue_pkg::ADDU, 5'd1, 5'd2, 5'd3), 2'd0);
        add_entry(r_word(issue_pkg::JR, 5'd31, 5'd0, 5'd0), 2'd0);
        add_entry(i_word(issue_pkg::SB, 5'd1, 5'd2, 16'd0), 2'd0);
        // Misaligned fetch addresses.
        add_entry(i_word(issue_pkg::LUI, 5'd0, 5'd7, 16'h1234), 2'd1);
        add_entry(r_word(issue_pkg::SLL, 5'd0, 5'd1, 5'd2), 2'd2);
        add_entry(i_word(issue_pkg::LH, 5'd1, 5'd2, 16'd0), 2'd3);
    endtask

    task automatic build_random(int n);
        issue_pkg::instr_word_u w;
        issue_pkg::instr_class_t c;
        logic prev_jb;
        int kind;
        prev_jb = 1'b0;
        for (int i = 0; i < n; i++)
        begin
            // Kinds 10 and up are branches and jumps, never placed in a delay slot.
            kind = prev_jb ? pick(10) : pick(14);
            case (kind)
                0: w = r_word(ALU_FUNCTS[pick(8)], rnd_reg(), rnd_reg(), rnd_reg());
                1: w = r_word(issue_pkg::SRA, 5'd0, rnd_reg(), rnd_reg());
                2: w = i_word(IMM_OPS[pick(5)], rnd_reg(), rnd_reg(), 16'($urandom));
                3: w = i_word(issue_pkg::LUI, 5'd0, rnd_reg(), 16'($urandom));
                4: w = i_word(LOAD_OPS[pick(5)], rnd_reg(), rnd_reg(), 16'd4);
                5: w = i_word(STORE_OPS[pick(3)], rnd_reg(), rnd_reg(), 16'd8);
                6: w = r_word(MULDIV_FUNCTS[pick(4)], rnd_reg(), rnd_reg(), 5'd0);
                7: w = r_word(pick(2) == 0 ? issue_pkg::MFHI : issue_pkg::MFLO,
                    5'd0, 5'd0, rnd_reg());
                8: w = r_word(pick(2) == 0 ? issue_pkg::MTHI : issue_pkg::MTLO,
                    rnd_reg(), 5'd0, 5'd0);
                9: w = i_word(pick(2) == 0 ? issue_pkg::COP0 : 6'b111111,
                    rnd_reg(), rnd_reg(), 16'd0);
                10: w = i_word(pick(2) == 0 ? issue_pkg::BEQ : issue_pkg::BNE,
                    rnd_reg(), rnd_reg(), 16'd8);
                11: w = i_word(pick(2) == 0 ? issue_pkg::BLEZ : issue_pkg::BGTZ,
                    rnd_reg(), 5'd0, 16'd8);
                12: w = i_word(issue_pkg::REGIMM, rnd_reg(), REGIMM_RT[pick(4)], 16'd8);
                default:
                begin
                    case (pick(4))
                        0: w = i_word(issue_pkg::J, 5'd0, 5'd0, 16'h0100);
                        1: w = i_word(issue_pkg::JAL, 5'd0, 5'd0, 16'h0200);
                        2: w = r_word(issue_pkg::JR, rnd_reg(), 5'd0, 5'd0);
                        default: w = r_word(issue_pkg::JALR, rnd_reg(), 5'd0, 5'd31);
                    endcase
                end
            endcase
            add_entry(w, pick(8) == 0 ? 2'(pick(4)) : 2'd0);
            c = ref_classify(w);
            prev_jb = c.is_branch || c.is_jump;
        end
    endtask

    // Compares on every edge with a valid bundle, so a stalled bundle must hold.
    always @(posedge clk)
    begin : compare
        issue_pkg::fetch_entry_t e0;
        issue_pkg::fetch_entry_t e1;
        issue_pkg::issue_bundle_t want;
        if (!rst)
        begin
            check_flag("in_ready", in_ready, model_q.size() < QUEUE_DEPTH);
            check_flag("out_valid", out_valid, model_q.size() != 0);
            if (!in_ready)
                saw_full = 1'b1;
            if (out_valid)
            begin
                e0 = '0;
                e1 = '0;
                if (model_q.size() > 0)
                    e0 = model_q[0];
                if (model_q.size() > 1)
                    e1 = model_q[1];
                want = ref_bundle(e0, e1, model_q.size(), model_slot);
                check_bundle(out_bundle, want);
                if (out_ready)
                begin
                    void'(model_q.pop_front());
                    if (want.beta.valid)
                    begin
                        void'(model_q.pop_front());
                        exp_dual++;
                    end
                    // Beta's slot mark tells whether alpha was a branch or jump.
                    model_slot = want.beta.in_delay_slot && !want.beta.valid;
                end
            end
            if (in_valid && in_ready)
            begin
                model_q.push_back(in_data);
                accepted++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            stop_with_failure();
        end
    end

    // Back-pressure. Held low at first so that the queue fills.
    initial
    begin
        out_ready = 1'b0;
        forever
        begin
            @(posedge clk);
            if (cycle_count < RESET_CYCLES + 12)
                out_ready <= 1'b0;
            else
                out_ready <= pick(10) < 6;
        end
    end

    initial
    begin
        int idx;
        void'($urandom(32'h1271));
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        pc = 32'h0040_0000;
        build_directed();
        build_random(N_RANDOM);
        cycle_limit = 20 * stim.size() + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        idx = 0;
        while (idx < stim.size())
        begin
            @(posedge clk);
            if (in_valid && in_ready)
                idx++;
            // An offered entry stays on the bus until it is taken.
            if (!(in_valid && !in_ready))
            begin
                if (idx < stim.size() && pick(5) != 0)
                begin
                    in_valid <= 1'b1;
                    in_data <= stim[idx];
                end
                else
                begin
                    in_valid <= 1'b0;
                end
            end
        end

        while (accepted != stim.size() || model_q.size() != 0)
            @(negedge clk);
        check_counts(issued_count, dual_count, 32'(stim.size()), 32'(exp_dual));

        if (!saw_full)
        begin
            $display("The queue never filled, so in_ready was never seen low.");
            stop_with_failure();
        end
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+tb
hdl/issue_pkg.sv
hdl/fetch_queue.sv
hdl/instr_classify.sv
hdl/pair_check.sv
hdl/delay_slot_fsm.sv
hdl/issue_stats.sv
hdl/issue_stage.sv
tb/tb_issue_stage.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f \
    --top-module tb_issue_stage -o sim_issue_stage
./obj_dir/sim_issue_stage | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    exit 1
fi
